//--- verilog/ex_pkg.sv
// execute stage package with word types, opcode and funct3 constants and decode enums
package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [3:0] {
        CLS_NONE,
        CLS_ALU,
        CLS_MUL,
        CLS_DIV,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_UPPER
    } ex_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // load and store sizes
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

    // branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_MUL    = 3'b000;
    localparam funct3_t F3_MULH   = 3'b001;
    localparam funct3_t F3_MULHSU = 3'b010;
    localparam funct3_t F3_MULHU  = 3'b011;
    localparam funct3_t F3_DIV    = 3'b100;
    localparam funct3_t F3_DIVU   = 3'b101;
    localparam funct3_t F3_REM    = 3'b110;
    localparam funct3_t F3_REMU   = 3'b111;

    // bit positions in compare_i
    localparam int CMP_EQ  = 0;
    localparam int CMP_GEU = 1;
    localparam int CMP_GE  = 2;

endpackage

//--- verilog/ex_control.sv
`timescale 1ns/1ns
// execute control decoding class and alu operation, resolving jumps, applying interrupt override
module ex_control (
    input  ex_pkg::word_t     inst_i,
    input  logic [2:0]        compare_i,     // eq, geu, ge of rs1 and rs2
    input  ex_pkg::word_t     op1_i,
    input  ex_pkg::word_t     op2_i,
    input  logic              int_assert_i,
    input  ex_pkg::word_t     int_addr_i,
    output ex_pkg::ex_class_e cls_o,
    output ex_pkg::alu_op_e   alu_op_o,
    output logic              div_valid_o,
    output logic              jump_flag_o,
    output ex_pkg::word_t     jump_addr_o
);
    import ex_pkg::*;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    logic [6:0] opcode;
    funct3_t    funct3;
    logic [6:0] funct7;
    logic       taken;
    logic       jump;
    word_t      target;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign target = op1_i + op2_i;    // branch offset or jalr base already in op2

    always_comb begin
        cls_o = CLS_NONE;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_MULDIV) begin
                    cls_o = funct3[2] ? CLS_DIV : CLS_MUL;
                end else if ((funct7 == F7_BASE) || (funct7 == F7_ALT)) begin
                    cls_o = CLS_ALU;
                end
            end
            OPC_OP_IMM:          cls_o = CLS_ALU;
            OPC_LOAD:            cls_o = CLS_LOAD;
            OPC_STORE:           cls_o = CLS_STORE;
            OPC_BRANCH:          cls_o = CLS_BRANCH;
            OPC_JAL, OPC_JALR:   cls_o = CLS_JUMP;
            OPC_LUI, OPC_AUIPC:  cls_o = CLS_UPPER;
            default:             cls_o = CLS_NONE;
        endcase
    end

    // bit 30 picks sub and sra; addi has no sub form
    always_comb begin
        case (funct3)
            3'b000:  alu_op_o = ((opcode == OPC_OP) && inst_i[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op_o = ALU_SLL;
            3'b010:  alu_op_o = ALU_SLT;
            3'b011:  alu_op_o = ALU_SLTU;
            3'b100:  alu_op_o = ALU_XOR;
            3'b101:  alu_op_o = inst_i[30] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op_o = ALU_OR;
            default: alu_op_o = ALU_AND;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = compare_i[CMP_EQ];
            F3_BNE:  taken = ~compare_i[CMP_EQ];
            F3_BLT:  taken = ~compare_i[CMP_GE];
            F3_BGE:  taken = compare_i[CMP_GE];
            F3_BLTU: taken = ~compare_i[CMP_GEU];
            F3_BGEU: taken = compare_i[CMP_GEU];
            default: taken = 1'b0;
        endcase
    end

    assign jump = (cls_o == CLS_JUMP) || ((cls_o == CLS_BRANCH) && taken);

    // interrupt wins over any jump
    assign jump_flag_o = int_assert_i | jump;
    assign jump_addr_o = int_assert_i ? int_addr_i : (jump ? target : '0);
    assign div_valid_o = (cls_o == CLS_DIV) && !int_assert_i;

endmodule

//--- verilog/ex_alu.sv
`timescale 1ns/1ns
// integer alu for add, sub, shifts, set-less-than and logic operations
module ex_alu (
    input  ex_pkg::alu_op_e alu_op_i,
    input  ex_pkg::word_t   op1_i,
    input  ex_pkg::word_t   op2_i,
    output ex_pkg::word_t   result_o
);
    import ex_pkg::*;

    logic [4:0] shamt;
    word_t      srl_res;
    word_t      sra_mask;
    logic       lt_s;
    logic       lt_u;

    assign shamt    = op2_i[4:0];           // also valid for the immediate forms
    assign srl_res  = op1_i >> shamt;
    assign sra_mask = 32'hffff_ffff >> shamt;
    assign lt_s     = $signed(op1_i) < $signed(op2_i);
    assign lt_u     = op1_i < op2_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_o = op1_i + op2_i;
            ALU_SUB:  result_o = op1_i - op2_i;
            ALU_SLL:  result_o = op1_i << shamt;
            ALU_SLT:  result_o = {31'b0, lt_s};
            ALU_SLTU: result_o = {31'b0, lt_u};
            ALU_XOR:  result_o = op1_i ^ op2_i;
            ALU_SRL:  result_o = srl_res;
            ALU_SRA:  result_o = srl_res | ({32{op1_i[31]}} & ~sra_mask);
            ALU_OR:   result_o = op1_i | op2_i;
            ALU_AND:  result_o = op1_i & op2_i;
            default:  result_o = '0;
        endcase
    end

endmodule

//--- verilog/ex_mul.sv
`timescale 1ns/1ns
// 32x32 multiplier with sign correction for mul, mulh, mulhsu and mulhu
module ex_mul (
    input  ex_pkg::funct3_t funct3_i,
    input  ex_pkg::word_t   op1_i,
    input  ex_pkg::word_t   op2_i,
    output ex_pkg::word_t   result_o
);
    import ex_pkg::*;

    logic   neg_op1;
    logic   neg_op2;
    logic   neg_prod;
    word_t  mul_op1;
    word_t  mul_op2;
    dword_t prod;
    dword_t prod_fix;

    // multiply magnitudes, then restore the sign of the product
    assign neg_op1 = ((funct3_i == F3_MULH) || (funct3_i == F3_MULHSU)) && op1_i[31];
    assign neg_op2 = (funct3_i == F3_MULH) && op2_i[31];

    assign mul_op1 = neg_op1 ? -op1_i : op1_i;
    assign mul_op2 = neg_op2 ? -op2_i : op2_i;

    assign prod     = dword_t'(mul_op1) * dword_t'(mul_op2);
    assign neg_prod = neg_op1 ^ neg_op2;
    assign prod_fix = neg_prod ? -prod : prod;

    // low word is the same for every signedness
    assign result_o = (funct3_i == F3_MUL) ? prod_fix[31:0] : prod_fix[63:32];

endmodule

//--- verilog/ex_div.sv
`timescale 1ns/1ns
// radix-2 restoring divider, 32 steps, for div, divu, rem and remu
module ex_div (
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            valid_i,
    input  ex_pkg::funct3_t funct3_i,
    input  ex_pkg::word_t   dividend_i,
    input  ex_pkg::word_t   divisor_i,
    output ex_pkg::word_t   data_o,
    output logic            ready_o
);
    import ex_pkg::*;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_e;

    div_state_e  state_q;
    logic [4:0]  count_q;
    word_t       quot_q;        // dividend shifts out, quotient shifts in
    word_t       rem_q;
    word_t       dsor_q;
    logic        is_rem_q;
    logic        neg_quot_q;
    logic        neg_rem_q;
    logic        signed_op;
    logic [32:0] trial;
    word_t       quot_fix;
    word_t       rem_fix;

    assign signed_op = (funct3_i == F3_DIV) || (funct3_i == F3_REM);
    assign trial     = {rem_q, quot_q[31]} - {1'b0, dsor_q};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= DIV_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                DIV_IDLE: begin
                    if (valid_i) begin
                        state_q <= DIV_BUSY;
                        count_q <= '0;
                    end
                end
                DIV_BUSY: begin
                    if (!valid_i) begin
                        state_q <= DIV_IDLE;    // aborted, e.g. by interrupt
                    end else if (count_q == 5'd31) begin
                        state_q <= DIV_DONE;
                    end
                    count_q <= count_q + 5'd1;
                end
                default: state_q <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == DIV_IDLE) && valid_i) begin
            quot_q     <= (signed_op && dividend_i[31]) ? -dividend_i : dividend_i;
            dsor_q     <= (signed_op && divisor_i[31]) ? -divisor_i : divisor_i;
            rem_q      <= '0;
            is_rem_q   <= (funct3_i == F3_REM) || (funct3_i == F3_REMU);
            // divide by zero keeps the all-ones quotient unsigned
            neg_quot_q <= signed_op && (dividend_i[31] ^ divisor_i[31]) && (divisor_i != '0);
            neg_rem_q  <= signed_op && dividend_i[31];
        end else if (state_q == DIV_BUSY) begin
            if (trial[32]) begin
                rem_q  <= {rem_q[30:0], quot_q[31]};
                quot_q <= {quot_q[30:0], 1'b0};
            end else begin
                rem_q  <= trial[31:0];
                quot_q <= {quot_q[30:0], 1'b1};
            end
        end
    end

    // most negative by -1 lands on quotient 0x8000_0000 and remainder 0 by itself
    assign quot_fix = neg_quot_q ? -quot_q : quot_q;
    assign rem_fix  = neg_rem_q ? -rem_q : rem_q;
    assign data_o   = is_rem_q ? rem_fix : quot_fix;
    assign ready_o  = (state_q == DIV_DONE);

endmodule

//--- verilog/ex_lsu.sv
`timescale 1ns/1ns
// load/store unit with load lane extraction, store lane merge and memory request
module ex_lsu (
    input  ex_pkg::ex_class_e cls_i,
    input  ex_pkg::funct3_t   funct3_i,
    input  ex_pkg::word_t     op1_i,
    input  ex_pkg::word_t     op2_i,
    input  ex_pkg::word_t     store_data_i,
    input  ex_pkg::word_t     mem_rdata_i,
    input  logic              mem_ready_i,
    output ex_pkg::word_t     load_data_o,
    output ex_pkg::word_t     mem_raddr_o,
    output ex_pkg::word_t     mem_waddr_o,
    output ex_pkg::word_t     mem_wdata_o,
    output logic              mem_req_o,
    output logic              mem_we_o,
    output logic              mem_hold_o
);
    import ex_pkg::*;

    word_t       addr;
    logic [1:0]  lane;
    logic        is_load;
    logic        is_store;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;
    logic [3:0]  be;            // lanes taken from the store data
    word_t       st_data;
    word_t       merged;

    assign addr     = op1_i + op2_i;
    assign lane     = addr[1:0];
    assign is_load  = (cls_i == CLS_LOAD);
    assign is_store = (cls_i == CLS_STORE);
    assign rd_byte  = mem_rdata_i[{lane, 3'b000} +: 8];
    assign rd_half  = lane[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

    always_comb begin
        case (funct3_i)
            F3_LB:   load_data_o = {{24{rd_byte[7]}}, rd_byte};
            F3_LBU:  load_data_o = {24'b0, rd_byte};
            F3_LH:   load_data_o = {{16{rd_half[15]}}, rd_half};
            F3_LHU:  load_data_o = {16'b0, rd_half};
            F3_LW:   load_data_o = mem_rdata_i;
            default: load_data_o = '0;
        endcase
    end

    // read-modify-write of the addressed word
    always_comb begin
        case (funct3_i)
            F3_SB: begin
                be      = 4'b0001 << lane;
                st_data = {4{store_data_i[7:0]}};
            end
            F3_SH: begin
                be      = lane[1] ? 4'b1100 : 4'b0011;
                st_data = {2{store_data_i[15:0]}};
            end
            default: begin
                be      = 4'b1111;
                st_data = store_data_i;
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = be[i] ? st_data[8*i +: 8] : mem_rdata_i[8*i +: 8];
        end
    end

    assign mem_req_o   = is_load | is_store;
    assign mem_we_o    = is_store;
    assign mem_raddr_o = mem_req_o ? addr : '0;    // stores read the word they merge into
    assign mem_waddr_o = is_store ? addr : '0;
    assign mem_wdata_o = is_store ? merged : '0;
    assign mem_hold_o  = mem_req_o & ~mem_ready_i;

endmodule

//--- verilog/ex_top.sv
`timescale 1ns/1ns
// execute stage top joining control, alu, multiplier, divider and lsu into write-back
module ex_top (
    input  logic              clk_i,
    input  logic              rst_i,
    input  ex_pkg::word_t     inst_i,
    input  ex_pkg::word_t     inst_addr_next_i,
    input  logic              reg_we_i,
    input  ex_pkg::reg_addr_t reg_waddr_i,
    input  ex_pkg::word_t     op1_i,
    input  ex_pkg::word_t     op2_i,
    input  ex_pkg::word_t     store_data_i,
    input  logic [2:0]        compare_i,
    input  logic              int_assert_i,
    input  ex_pkg::word_t     int_addr_i,
    input  ex_pkg::word_t     mem_rdata_i,
    input  logic              mem_ready_i,
    output ex_pkg::word_t     reg_wdata_o,
    output logic              reg_we_o,
    output ex_pkg::reg_addr_t reg_waddr_o,
    output ex_pkg::word_t     mem_wdata_o,
    output ex_pkg::word_t     mem_raddr_o,
    output ex_pkg::word_t     mem_waddr_o,
    output logic              mem_we_o,
    output logic              mem_req_o,
    output logic              ready_o,
    output logic              jump_flag_o,
    output ex_pkg::word_t     jump_addr_o
);
    import ex_pkg::*;

    ex_class_e cls;
    alu_op_e   alu_op;
    funct3_t   funct3;
    word_t     alu_res;
    word_t     mul_res;
    word_t     div_data;
    word_t     load_data;
    logic      div_valid;
    logic      div_ready;
    logic      div_hold;
    logic      mem_req;
    logic      mem_we;
    logic      mem_hold;
    logic      reg_we;

    assign funct3 = inst_i[14:12];

    ex_control i_ex_control (
        .inst_i,
        .compare_i,
        .op1_i,
        .op2_i,
        .int_assert_i,
        .int_addr_i,
        .cls_o       (cls),
        .alu_op_o    (alu_op),
        .div_valid_o (div_valid),
        .jump_flag_o,
        .jump_addr_o
    );

    ex_alu i_ex_alu (
        .alu_op_i (alu_op),
        .op1_i,
        .op2_i,
        .result_o (alu_res)
    );

    ex_mul i_ex_mul (
        .funct3_i (funct3),
        .op1_i,
        .op2_i,
        .result_o (mul_res)
    );

    ex_div i_ex_div (
        .clk_i,
        .rst_i,
        .valid_i    (div_valid),
        .funct3_i   (funct3),
        .dividend_i (op1_i),
        .divisor_i  (op2_i),
        .data_o     (div_data),
        .ready_o    (div_ready)
    );

    ex_lsu i_ex_lsu (
        .cls_i       (cls),
        .funct3_i    (funct3),
        .op1_i,
        .op2_i,
        .store_data_i,
        .mem_rdata_i,
        .mem_ready_i,
        .load_data_o (load_data),
        .mem_raddr_o,
        .mem_waddr_o,
        .mem_wdata_o,
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_hold_o  (mem_hold)
    );

    always_comb begin
        reg_we = reg_we_i;
        case (cls)
            CLS_ALU:   reg_wdata_o = alu_res;
            CLS_MUL:   reg_wdata_o = mul_res;
            CLS_DIV: begin
                reg_wdata_o = div_data;
                reg_we      = reg_we_i & div_valid & div_ready;   // only in the done cycle
            end
            CLS_LOAD:  reg_wdata_o = load_data;
            CLS_JUMP:  reg_wdata_o = inst_addr_next_i;            // link value
            CLS_UPPER: reg_wdata_o = op1_i + op2_i;               // lui: op1 is zero
            default:   reg_wdata_o = '0;
        endcase
    end

    assign div_hold    = div_valid & ~div_ready;
    assign reg_we_o    = reg_we & ~int_assert_i;
    assign reg_waddr_o = reg_waddr_i;
    assign mem_req_o   = mem_req & ~int_assert_i;
    assign mem_we_o    = mem_we & ~int_assert_i;

    // no request goes out under interrupt, so nothing to wait for
    assign ready_o = ~(div_hold | (mem_hold & ~int_assert_i));

endmodule

//--- bench/ex_assert.sv
`timescale 1ns/1ns
// interrupt and stall properties of the execute stage, bound into ex_top
module ex_assert (
    input logic          clk_i,
    input logic          rst_i,
    input logic          int_assert_i,
    input ex_pkg::word_t int_addr_i,
    input logic          mem_ready_i,
    input logic          reg_we_o,
    input logic          mem_req_o,
    input logic          ready_o,
    input ex_pkg::word_t jump_addr_o
);

    int failures = 0;    // assertion failures seen so far

    // no write of any kind while the interrupt is taken
    irq_blocks_writes: assert property (@(posedge clk_i) disable iff (rst_i)
        int_assert_i |-> (!reg_we_o && !mem_req_o))
        else begin
            $error("register or memory write while int_assert_i is high");
            failures++;
        end

    irq_jump_target: assert property (@(posedge clk_i) disable iff (rst_i)
        int_assert_i |-> (jump_addr_o == int_addr_i))
        else begin
            $error("jump_addr_o differs from int_addr_i under interrupt");
            failures++;
        end

    mem_wait_stalls: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem_req_o && !mem_ready_i) |-> !ready_o)
        else begin
            $error("ready_o high while a memory request waits");
            failures++;
        end

endmodule

bind ex_top ex_assert i_ex_assert (.*);

//--- bench/tb_ex.sv
`timescale 1ns/1ns
// testbench for the execute stage with random instructions, a word memory and a reference model
module tb_ex;
    import ex_pkg::*;

    localparam int N_ALU   = 200;
    localparam int N_MUL   = 100;
    localparam int N_DIV   = 30;
    localparam int N_IDIV  = 10;
    localparam int N_MEM   = 120;
    localparam int N_BR    = 100;
    localparam int N_IRQ   = 40;
    localparam int N_TESTS = N_ALU + N_MUL + N_DIV + N_IDIV + N_MEM + N_BR + N_IRQ;
    localparam int TIMEOUT_NS = (N_TESTS * 40 + 200) * 40;
    localparam logic [31:0] SEED = 32'h8c05_c587;

    logic      clk_i = 1'b0;
    logic      rst_i;
    word_t     inst_i;
    word_t     inst_addr_next_i;
    logic      reg_we_i;
    reg_addr_t reg_waddr_i;
    word_t     op1_i;
    word_t     op2_i;
    word_t     store_data_i;
    logic [2:0] compare_i;
    logic      int_assert_i;
    word_t     int_addr_i;
    word_t     mem_rdata_i;
    logic      mem_ready_i;
    word_t     reg_wdata_o;
    logic      reg_we_o;
    reg_addr_t reg_waddr_o;
    word_t     mem_wdata_o;
    word_t     mem_raddr_o;
    word_t     mem_waddr_o;
    logic      mem_we_o;
    logic      mem_req_o;
    logic      ready_o;
    logic      jump_flag_o;
    word_t     jump_addr_o;

    word_t     mem [16];      // aliased over the address space
    int        errors = 0;

    always #20 clk_i = ~clk_i;

    ex_top i_ex_top (.*);

    assign mem_rdata_i = mem[mem_raddr_o[5:2]];

    always @(posedge clk_i) begin
        if (mem_we_o && mem_ready_i) begin
            mem[mem_waddr_o[5:2]] <= mem_wdata_o;
        end
    end

    task automatic check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s at %0t ns, got %h expected %h", name, $time, got, exp);
        end
    endtask

    function automatic word_t encode(logic [6:0] f7, funct3_t f3, logic [6:0] opc);
        word_t r;
        r = $urandom;
        return {f7, r[9:0], f3, r[14:10], opc};
    endfunction

    function automatic word_t pick_operand();
        case ($urandom_range(0, 7))
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h8000_0000;
            4:       return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic word_t alu_model(funct3_t f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // sign or zero extended 64-bit products, wrapping is exact
    function automatic word_t mul_model(funct3_t f3, word_t a, word_t b);
        dword_t sa;
        dword_t sb;
        dword_t ua;
        dword_t ub;
        dword_t p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        case (f3)
            F3_MUL:    p = ua * ub;
            F3_MULH:   p = sa * sb;
            F3_MULHSU: p = sa * ub;
            default:   p = ua * ub;
        endcase
        return (f3 == F3_MUL) ? p[31:0] : p[63:32];
    endfunction

    function automatic word_t div_model(funct3_t f3, word_t a, word_t b);
        logic  is_signed;
        word_t q;
        word_t r;
        is_signed = (f3 == F3_DIV) || (f3 == F3_REM);
        if (b == '0) begin
            q = '1;
            r = a;
        end else if (is_signed && (a == 32'h8000_0000) && (b == '1)) begin
            q = a;
            r = '0;
        end else if (is_signed) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return ((f3 == F3_REM) || (f3 == F3_REMU)) ? r : q;
    endfunction

    function automatic word_t load_model(funct3_t f3, word_t w, int lane);
        word_t s;
        s = w >> (8 * lane);
        case (f3)
            F3_LB:   return {{24{s[7]}}, s[7:0]};
            F3_LBU:  return {24'b0, s[7:0]};
            F3_LH:   return {{16{s[15]}}, s[15:0]};
            F3_LHU:  return {16'b0, s[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic word_t store_model(funct3_t f3, word_t old, word_t d, int lane);
        word_t res;
        res = old;
        case (f3)
            F3_SB:   res[8*lane +: 8] = d[7:0];
            F3_SH:   res[8*lane +: 16] = d[15:0];
            default: res = d;
        endcase
        return res;
    endfunction

    // one instruction per falling edge, outputs read 5 ns later
    task automatic issue(input word_t inst, input word_t a, input word_t b, input word_t sdata,
                         input logic [2:0] cmp, input logic irq, input logic rdy);
        @(negedge clk_i);
        inst_i           = inst;
        op1_i            = a;
        op2_i            = b;
        store_data_i     = sdata;
        compare_i        = cmp;
        int_assert_i     = irq;
        mem_ready_i      = rdy;
        reg_we_i         = $urandom_range(0, 1);
        reg_waddr_i      = $urandom;
        inst_addr_next_i = $urandom;
        int_addr_i       = $urandom;
        #5;
    endtask

    task automatic check_writeback(input word_t exp);
        check("reg_wdata_o", reg_wdata_o, exp);
        check("reg_we_o", reg_we_o, reg_we_i);
        check("reg_waddr_o", reg_waddr_o, reg_waddr_i);
        check("jump_flag_o", jump_flag_o, 1'b0);
        check("mem_req_o", mem_req_o, 1'b0);
        check("ready_o", ready_o, 1'b1);
    endtask

    task automatic check_irq();
        check("reg_we_o", reg_we_o, 1'b0);
        check("mem_req_o", mem_req_o, 1'b0);
        check("mem_we_o", mem_we_o, 1'b0);
        check("jump_flag_o", jump_flag_o, 1'b1);
        check("jump_addr_o", jump_addr_o, int_addr_i);
        check("ready_o", ready_o, 1'b1);
    endtask

    task automatic run_alu();
        funct3_t    f3;
        logic       is_reg;
        logic       alt;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      r;
        f3     = $urandom;
        is_reg = $urandom_range(0, 1);
        alt    = $urandom_range(0, 1);
        a      = pick_operand();
        r      = $urandom;
        if ($urandom_range(0, 7) == 0) begin
            b = {r[31:12], 12'b0};    // lui has a zero op1
            issue(encode(r[31:25], r[14:12], alt ? OPC_LUI : OPC_AUIPC), alt ? '0 : a, b,
                  '0, 3'b000, 1'b0, 1'b1);
            check_writeback((alt ? 32'd0 : a) + b);
        end else begin
            if (is_reg) begin
                b  = pick_operand();
                f7 = (alt && ((f3 == 3'b000) || (f3 == 3'b101))) ? 7'h20 : 7'h00;
            end else if ((f3 == 3'b001) || (f3 == 3'b101)) begin
                f7 = (alt && (f3 == 3'b101)) ? 7'h20 : 7'h00;
                b  = {20'b0, f7, r[4:0]};
            end else begin
                b  = {{20{r[11]}}, r[11:0]};
                f7 = b[11:5];
            end
            issue(encode(f7, f3, is_reg ? OPC_OP : OPC_OP_IMM), a, b, '0, 3'b000, 1'b0, 1'b1);
            check_writeback(alu_model(f3, f7[5] && (is_reg || (f3 == 3'b101)), a, b));
        end
    endtask

    task automatic run_mul();
        funct3_t f3;
        word_t   a;
        word_t   b;
        f3 = funct3_t'($urandom_range(0, 3));
        a  = pick_operand();
        b  = pick_operand();
        issue(encode(7'h01, f3, OPC_OP), a, b, '0, 3'b000, 1'b0, 1'b1);
        check_writeback(mul_model(f3, a, b));
    endtask

    task automatic run_div(input logic interrupt_first);
        funct3_t f3;
        word_t   a;
        word_t   b;
        word_t   inst;
        int      sel;
        int      cycles;
        f3  = funct3_t'(4 + $urandom_range(0, 3));
        sel = $urandom_range(0, 5);
        a   = pick_operand();
        b   = pick_operand();
        if (sel == 0) b = '0;
        if (sel == 1) begin
            a = 32'h8000_0000;
            b = 32'hffff_ffff;
        end
        inst = encode(7'h01, f3, OPC_OP);
        if (interrupt_first) begin
            issue(inst, a, b, '0, 3'b000, 1'b0, 1'b1);
            repeat ($urandom_range(1, 30)) @(negedge clk_i);
            issue(inst, a, b, '0, 3'b000, 1'b1, 1'b1);
            check_irq();
        end
        issue(inst, a, b, '0, 3'b000, 1'b0, 1'b1);
        cycles = 0;
        while ((ready_o !== 1'b1) && (cycles < 40)) begin
            check("reg_we_o", reg_we_o, 1'b0);
            @(negedge clk_i);
            #5;
            cycles++;
        end
        if (ready_o !== 1'b1) begin
            errors++;
            $display("divider gave no result within 40 cycles");
        end
        check("divide latency", cycles, 33);
        check_writeback(div_model(f3, a, b));
        issue('0, '0, '0, '0, 3'b000, 1'b0, 1'b1);    // bubble so the divider returns to idle
    endtask

    task automatic check_mem(input logic is_store, input word_t addr, input word_t exp);
        check("mem_req_o", mem_req_o, 1'b1);
        check("mem_we_o", mem_we_o, is_store);
        check("mem_raddr_o", mem_raddr_o, addr);
        if (is_store) begin
            check("mem_waddr_o", mem_waddr_o, addr);
            check("mem_wdata_o", mem_wdata_o, exp);
        end
    endtask

    task automatic run_mem();
        logic    is_store;
        logic    uns;
        int      size;
        int      delay;
        funct3_t f3;
        word_t   a;
        word_t   b;
        word_t   addr;
        word_t   exp;
        is_store = $urandom_range(0, 1);
        size     = $urandom_range(0, 2);
        uns      = (size < 2) && !is_store && ($urandom_range(0, 1) != 0);
        f3       = funct3_t'(size) | (uns ? 3'b100 : 3'b000);
        a        = $urandom & 32'hffff_fffc;
        b        = $urandom_range(0, 63) & ~((1 << size) - 1);    // aligned offset
        addr     = a + b;
        delay    = $urandom_range(0, 3);
        issue(encode(7'h00, f3, is_store ? OPC_STORE : OPC_LOAD), a, b, $urandom, 3'b000,
              1'b0, delay == 0);
        if (is_store) exp = store_model(f3, mem[addr[5:2]], store_data_i, int'(addr[1:0]));
        else exp = load_model(f3, mem[addr[5:2]], int'(addr[1:0]));
        for (int d = delay; d > 0; d--) begin
            check("ready_o", ready_o, 1'b0);
            check_mem(is_store, addr, exp);
            @(negedge clk_i);
            if (d == 1) mem_ready_i = 1'b1;
            #5;
        end
        check("ready_o", ready_o, 1'b1);
        check_mem(is_store, addr, exp);
        check("reg_we_o", reg_we_o, reg_we_i);
        if (!is_store) check("reg_wdata_o", reg_wdata_o, exp);
    endtask

    task automatic run_branch();
        int         kind;
        funct3_t    f3;
        logic [6:0] opc;
        logic [2:0] cmp;
        logic       taken;
        word_t      rs1;
        word_t      rs2;
        word_t      a;
        word_t      b;
        kind = $urandom_range(0, 7);
        rs1  = pick_operand();
        rs2  = ($urandom_range(0, 3) == 0) ? rs1 : pick_operand();
        cmp[CMP_EQ]  = (rs1 == rs2);
        cmp[CMP_GEU] = (rs1 >= rs2);
        cmp[CMP_GE]  = ($signed(rs1) >= $signed(rs2));
        opc = (kind == 6) ? OPC_JAL : ((kind == 7) ? OPC_JALR : OPC_BRANCH);
        f3  = (kind < 2) ? funct3_t'(kind) : ((kind < 6) ? funct3_t'(kind + 2) : 3'b000);
        case (f3)
            F3_BEQ:  taken = (rs1 == rs2);
            F3_BNE:  taken = (rs1 != rs2);
            F3_BLT:  taken = ($signed(rs1) < $signed(rs2));
            F3_BGE:  taken = ($signed(rs1) >= $signed(rs2));
            F3_BLTU: taken = (rs1 < rs2);
            default: taken = (rs1 >= rs2);
        endcase
        if (opc != OPC_BRANCH) taken = 1'b1;
        a = $urandom;
        b = $urandom;
        issue(encode(7'h00, f3, opc), a, b, '0, cmp, 1'b0, 1'b1);
        check("jump_flag_o", jump_flag_o, taken);
        if (taken) check("jump_addr_o", jump_addr_o, a + b);
        if (opc != OPC_BRANCH) begin
            check("reg_wdata_o", reg_wdata_o, inst_addr_next_i);    // link value
            check("reg_we_o", reg_we_o, reg_we_i);
        end
        check("ready_o", ready_o, 1'b1);
    endtask

    task automatic run_irq();
        logic [6:0] opc;
        logic [6:0] f7;
        case ($urandom_range(0, 6))
            0:       opc = OPC_OP;
            1:       opc = OPC_OP_IMM;
            2:       opc = OPC_LOAD;
            3:       opc = OPC_STORE;
            4:       opc = OPC_BRANCH;
            5:       opc = OPC_JAL;
            default: opc = OPC_JALR;
        endcase
        f7 = ($urandom_range(0, 1) != 0) ? 7'h01 : 7'h00;    // mul and div under OPC_OP
        issue(encode(f7, funct3_t'($urandom), opc), $urandom, $urandom, $urandom,
              3'($urandom), 1'b1, $urandom_range(0, 1));
        check_irq();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before all tests were done");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst_i            = 1'b1;
        inst_i           = '0;
        inst_addr_next_i = '0;
        reg_we_i         = 1'b0;
        reg_waddr_i      = '0;
        op1_i            = '0;
        op2_i            = '0;
        store_data_i     = '0;
        compare_i        = '0;
        int_assert_i     = 1'b0;
        int_addr_i       = '0;
        mem_ready_i      = 1'b1;
        for (int i = 0; i < 16; i++) begin
            mem[i] <= $urandom;
        end
        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;

        repeat (N_ALU) run_alu();
        repeat (N_MUL) run_mul();
        repeat (N_DIV) run_div(1'b0);
        repeat (N_MEM) run_mem();
        repeat (N_BR) run_branch();
        repeat (N_IRQ) run_irq();
        repeat (N_IDIV) run_div(1'b1);    // aborted divide, then a full one

        $display("%0d check errors, %0d assertion failures in %0d tests",
                 errors, i_ex_top.i_ex_assert.failures, N_TESTS);
        if ((errors == 0) && (i_ex_top.i_ex_assert.failures == 0)) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- flist.f
verilog/ex_pkg.sv
verilog/ex_control.sv
verilog/ex_alu.sv
verilog/ex_mul.sv
verilog/ex_div.sv
verilog/ex_lsu.sv
verilog/ex_top.sv
bench/ex_assert.sv
bench/tb_ex.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  - verilog/ex_pkg.sv
  - verilog/ex_control.sv
  - verilog/ex_alu.sv
  - verilog/ex_mul.sv
  - verilog/ex_div.sv
  - verilog/ex_lsu.sv
  - verilog/ex_top.sv
  - target: simulation
    files:
      - bench/ex_assert.sv
      - bench/tb_ex.sv
